// File: src/decoder_host_pkg.sv
// Decoder host widths, decode state enum, LFSR seed and taps, trigger bytes
package decoder_host_pkg;

    // Datapath widths
    localparam int unsigned code_width_lp   = 8;
    localparam int unsigned result_width_lp = 16;
    localparam int unsigned addr_width_lp   = 13;

    // One-hot select index, 4 bits for a 16-bit result
    localparam int unsigned result_sel_width_lp = $clog2(result_width_lp);

    // LFSR geometry
    localparam int unsigned lfsr_width_lp = 128;

    // Any nonzero value works
    localparam logic [lfsr_width_lp-1:0] lfsr_seed_default_lp =
        128'hFEDC_BA98_7654_3210_FEDC_BA98_7654_3210;

    // Feedback taps, each XORed with the top bit
    localparam int unsigned lfsr_tap_a_lp = 6;
    localparam int unsigned lfsr_tap_b_lp = 1;
    localparam int unsigned lfsr_tap_c_lp = 0;

    // Byte seen by the trigger
    localparam int unsigned trigger_byte_width_lp = 8;

    // Byte pair that fires the forced clear, first then second
    localparam logic [trigger_byte_width_lp-1:0] trigger_first_lp  = 8'hAA;
    localparam logic [trigger_byte_width_lp-1:0] trigger_second_lp = 8'h55;

    // Decode sequence
    typedef enum logic [1:0] {
        DEC_IDLE    = 2'd0, // Clear result
        DEC_CAPTURE = 2'd1, // Latch one-hot bit
        DEC_READY   = 2'd2, // Raise valid
        DEC_WAIT    = 2'd3  // Drop valid
    } decode_state_e;

endpackage : decoder_host_pkg

// File: src/lfsr_source.sv
// 128-bit Fibonacci LFSR stepping on enable, low byte output
`timescale 1ns/1ps

module lfsr_source
    import decoder_host_pkg::*;
#(
    parameter logic [lfsr_width_lp-1:0] seed = lfsr_seed_default_lp
) (
    input  logic                             clk,
    input  logic                             pon_rst_i,
    input  logic                             enable_i,
    output logic [trigger_byte_width_lp-1:0] lfsr_byte_o
);

    logic [lfsr_width_lp-1:0] lfsr_q;
    logic                     feedback;

    // Top bit XOR the three low taps
    assign feedback = lfsr_q[lfsr_width_lp-1] ^ lfsr_q[lfsr_tap_a_lp]
                    ^ lfsr_q[lfsr_tap_b_lp] ^ lfsr_q[lfsr_tap_c_lp];

    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            lfsr_q <= seed;
        end else if (enable_i) begin
            lfsr_q <= {lfsr_q[lfsr_width_lp-2:0], feedback}; // Shift left, new bit in at 0
        end
    end

    assign lfsr_byte_o = lfsr_q[trigger_byte_width_lp-1:0];

endmodule : lfsr_source

// File: src/sequence_trigger.sv
// Byte-pair detector for 0xAA then 0x55, registered one-cycle clear pulse
`timescale 1ns/1ps

module sequence_trigger
    import decoder_host_pkg::*;
(
    input  logic                             clk,
    input  logic                             pon_rst_i,
    input  logic [trigger_byte_width_lp-1:0] data_i,
    output logic                             force_clear_o
);

    logic [trigger_byte_width_lp-1:0] prev_byte_q;
    logic                             first_seen;
    logic                             second_seen;
    logic                             pair_hit;
    logic                             force_clear_q;

    // Compare last cycle's byte and this cycle's byte
    assign first_seen  = (prev_byte_q == trigger_first_lp);
    assign second_seen = (data_i == trigger_second_lp);
    assign pair_hit    = first_seen & second_seen;

    // Previous byte, sampled every edge whether or not the source steps
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            prev_byte_q <= '0;
        end else begin
            prev_byte_q <= data_i;
        end
    end

    /*
     * The pulse lasts one cycle because prev_byte_q moves on to the
     * second byte at the same edge that loads the pulse
     */
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            force_clear_q <= 1'b0;
        end else begin
            force_clear_q <= pair_hit;
        end
    end

    assign force_clear_o = force_clear_q;

endmodule : sequence_trigger

// File: src/onehot_decode_fsm.sv
// Four-state decode sequencer with one-hot result and one-cycle valid
`timescale 1ns/1ps

module onehot_decode_fsm
    import decoder_host_pkg::*;
(
    input  logic                       clk,
    input  logic                       pon_rst_i,
    input  logic                       enable_i,
    input  logic                       force_clear_i,
    input  logic [code_width_lp-1:0]   code_i,
    output logic [result_width_lp-1:0] result_o,
    output logic                       valid_o
);

    decode_state_e                  state_q;
    logic [result_width_lp-1:0]     result_q;
    logic                           valid_q;
    logic                           code_in_range;
    logic [result_sel_width_lp-1:0] code_sel;

    // Only codes that map onto the result width get a bit
    assign code_in_range = (code_i < result_width_lp);
    assign code_sel      = code_i[result_sel_width_lp-1:0];

    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            state_q  <= DEC_IDLE;
            result_q <= '0;
            valid_q  <= 1'b0;
        end else if (force_clear_i) begin // Trigger wins over everything
            state_q  <= DEC_IDLE;
            result_q <= '0;
            valid_q  <= 1'b0;
        end else if (enable_i) begin
            case (state_q)
                DEC_IDLE: begin
                    result_q <= '0;
                    state_q  <= DEC_CAPTURE;
                end
                DEC_CAPTURE: begin
                    if (code_in_range) begin
                        result_q[code_sel] <= 1'b1;
                    end
                    state_q <= DEC_READY;
                end
                DEC_READY: begin
                    valid_q <= 1'b1; // High for the next cycle only
                    state_q <= DEC_WAIT;
                end
                DEC_WAIT: begin
                    valid_q <= 1'b0;
                    state_q <= DEC_IDLE;
                end
                default: begin
                    state_q <= DEC_IDLE;
                end
            endcase
        end else begin
            // Paused, state and result hold
            valid_q <= 1'b0;
        end
    end

    assign result_o = result_q;
    assign valid_o  = valid_q;

endmodule : onehot_decode_fsm

// File: src/program_address_gen.sv
// Enabled program address counter with registered address output
`timescale 1ns/1ps

module program_address_gen
    import decoder_host_pkg::*;
(
    input  logic                     clk,
    input  logic                     pon_rst_i,
    input  logic                     enable_i,
    input  logic                     force_clear_i,
    output logic [addr_width_lp-1:0] prog_adr_o
);

    logic [addr_width_lp-1:0] count_q;
    logic [addr_width_lp-1:0] adr_q;

    // Wraps at 8192 by width
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            count_q <= '0;
        end else if (force_clear_i) begin
            count_q <= '0;
        end else if (enable_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Lags the counter by one edge
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            adr_q <= '0;
        end else if (force_clear_i) begin
            adr_q <= '0;
        end else begin
            adr_q <= count_q;
        end
    end

    assign prog_adr_o = adr_q;

endmodule : program_address_gen

// File: src/decoder_host_top.sv
// Decoder host top level wiring LFSR, trigger, decoder and address generator
`timescale 1ns/1ps

module decoder_host_top
    import decoder_host_pkg::*;
#(
    parameter logic [lfsr_width_lp-1:0] lfsr_seed = lfsr_seed_default_lp
) (
    input  logic                       clk,
    input  logic                       pon_rst_i,
    input  logic [code_width_lp-1:0]   encoded_input_i,
    input  logic                       decode_enable_i,
    output logic [result_width_lp-1:0] decoded_output_o,
    output logic                       decode_valid_o,
    output logic [addr_width_lp-1:0]   prog_adr_o
);

    logic [trigger_byte_width_lp-1:0] lfsr_byte;   // LFSR low byte to trigger
    logic                             force_clear; // One-cycle clear pulse

    lfsr_source #(
        .seed (lfsr_seed)
    ) u_lfsr_source (
        .clk         (clk),
        .pon_rst_i   (pon_rst_i),
        .enable_i    (decode_enable_i),
        .lfsr_byte_o (lfsr_byte)
    );

    sequence_trigger u_sequence_trigger (
        .clk           (clk),
        .pon_rst_i     (pon_rst_i),
        .data_i        (lfsr_byte),
        .force_clear_o (force_clear)
    );

    // Decode stage
    onehot_decode_fsm u_onehot_decode_fsm (
        .clk           (clk),
        .pon_rst_i     (pon_rst_i),
        .enable_i      (decode_enable_i),
        .force_clear_i (force_clear),
        .code_i        (encoded_input_i),
        .result_o      (decoded_output_o),
        .valid_o       (decode_valid_o)
    );

    // Result stage
    program_address_gen u_program_address_gen (
        .clk           (clk),
        .pon_rst_i     (pon_rst_i),
        .enable_i      (decode_enable_i),
        .force_clear_i (force_clear),
        .prog_adr_o    (prog_adr_o)
    );

endmodule : decoder_host_top

// File: testbench/tb_decoder_host.sv
// Table-driven testbench for the decoder host with reference model and output checks
`timescale 1ns/1ps

module tb_decoder_host
    import decoder_host_pkg::*;
;

    // Low byte 0xAA and bit 127 clear so the first step gives 0x55
    localparam logic [lfsr_width_lp-1:0] tb_seed_lp =
        128'h0F1E_2D3C_4B5A_6978_8796_A5B4_C3D2_E1AA;

    typedef struct packed {
        logic                     en;   // Enable level
        logic                     rnd;  // Random filler code
        logic [code_width_lp-1:0] code;
        logic [15:0]              reps;
    } stim_row_t;

    logic                       clk;
    logic                       pon_rst;
    logic [code_width_lp-1:0]   encoded_input;
    logic                       decode_enable;
    logic [result_width_lp-1:0] decoded_output;
    logic                       decode_valid;
    logic [addr_width_lp-1:0]   prog_adr;

    stim_row_t stim_table[$];
    int        cycle_count   = 0;
    int        timeout_limit = 0;

    // Reference model state
    logic [lfsr_width_lp-1:0]         m_lfsr;
    logic [trigger_byte_width_lp-1:0] m_prev_byte;
    logic                             m_clear;
    decode_state_e                    m_state;
    logic [result_width_lp-1:0]       m_result;
    logic                             m_valid;
    logic [addr_width_lp-1:0]         m_count;
    logic [addr_width_lp-1:0]         m_adr;

    decoder_host_top #(
        .lfsr_seed (tb_seed_lp)
    ) uut (
        .clk              (clk),
        .pon_rst_i        (pon_rst),
        .encoded_input_i  (encoded_input),
        .decode_enable_i  (decode_enable),
        .decoded_output_o (decoded_output),
        .decode_valid_o   (decode_valid),
        .prog_adr_o       (prog_adr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("Timeout, the test did not finish within %0d cycles", timeout_limit);
            $display(">>> FAIL");
            $fatal(1, "simulation hung");
        end
    end

    task automatic add_row(input logic en, input logic rnd,
                           input logic [code_width_lp-1:0] code, input int reps);
        stim_row_t row;
        row.en   = en;
        row.rnd  = rnd;
        row.code = code;
        row.reps = 16'(reps);
        stim_table.push_back(row);
    endtask

    task automatic build_table();
        add_row(1'b0, 1'b0, 8'h00, 3);  // Idle after reset
        add_row(1'b1, 1'b0, 8'h00, 4);  // Trigger pair fires in here
        for (int k = 0; k < 16; k++) begin
            add_row(1'b1, 1'b0, code_width_lp'(k), 4); // One capture per row
        end
        add_row(1'b0, 1'b0, 8'h03, 3);  // Pause
        add_row(1'b1, 1'b0, 8'h10, 4);
        add_row(1'b1, 1'b0, 8'h7F, 4);
        add_row(1'b1, 1'b0, 8'hFF, 4);
        add_row(1'b1, 1'b1, 8'h00, 40);
        add_row(1'b0, 1'b1, 8'h00, 2);
        add_row(1'b1, 1'b1, 8'h00, 6);
        add_row(1'b0, 1'b1, 8'h00, 1);
        add_row(1'b1, 1'b1, 8'h00, 5);
        add_row(1'b0, 1'b0, 8'h00, 4);  // Drain
    endtask

    // One rising edge of the reference with inputs as sampled at that edge
    task automatic step_model(input logic en, input logic [code_width_lp-1:0] code);
        logic [trigger_byte_width_lp-1:0] cur_byte;
        logic                             clr;
        logic                             fb;
        logic [addr_width_lp-1:0]         old_count;
        cur_byte  = m_lfsr[trigger_byte_width_lp-1:0];
        clr       = m_clear;
        old_count = m_count;
        m_clear = (m_prev_byte == trigger_first_lp) && (cur_byte == trigger_second_lp);
        m_prev_byte = cur_byte;
        if (en) begin
            fb = m_lfsr[lfsr_width_lp-1] ^ m_lfsr[lfsr_tap_a_lp]
               ^ m_lfsr[lfsr_tap_b_lp] ^ m_lfsr[lfsr_tap_c_lp];
            m_lfsr = {m_lfsr[lfsr_width_lp-2:0], fb};
        end
        if (clr) begin
            m_state  = DEC_IDLE;
            m_result = '0;
            m_valid  = 1'b0;
        end else if (en) begin
            case (m_state)
                DEC_IDLE:    m_result = '0;
                DEC_CAPTURE: begin
                    if (code < code_width_lp'(result_width_lp)) begin
                        m_result = m_result | (result_width_lp'(1) << code);
                    end
                end
                DEC_READY:   m_valid = 1'b1;
                default:     m_valid = 1'b0;
            endcase
            m_state = decode_state_e'(m_state + 2'd1); // Sequence wraps WAIT to IDLE
        end else begin
            m_valid = 1'b0;
        end
        if (clr) begin
            m_count = '0;
            m_adr   = '0;
        end else begin
            m_adr = old_count;
            if (en) begin
                m_count = m_count + 1'b1;
            end
        end
    endtask

    task automatic check_result(input logic [result_width_lp-1:0] exp,
                                input logic [result_width_lp-1:0] act);
        if (act !== exp) begin
            $display("error: decoded_output_o expected 0x%h actual 0x%h", exp, act);
            $display(">>> FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: decode_valid_o expected 0x%h actual 0x%h", exp, act);
            $display(">>> FAIL");
            $fatal(1, "valid mismatch");
        end
    endtask

    task automatic check_address(input logic [addr_width_lp-1:0] exp,
                                 input logic [addr_width_lp-1:0] act);
        if (act !== exp) begin
            $display("error: prog_adr_o expected 0x%h actual 0x%h", exp, act);
            $display(">>> FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    initial begin
        int total_reps;
        logic [code_width_lp-1:0] next_code;
        pon_rst       <= 1'b1;
        decode_enable <= 1'b0;
        encoded_input <= '0;
        void'($urandom(32'h46ef_6ab7));
        build_table();
        total_reps = 0;
        foreach (stim_table[i]) begin
            total_reps = total_reps + int'(stim_table[i].reps);
        end
        timeout_limit = total_reps + 20;

        // Model matches the reset values
        m_lfsr      = tb_seed_lp;
        m_prev_byte = '0;
        m_clear     = 1'b0;
        m_state     = DEC_IDLE;
        m_result    = '0;
        m_valid     = 1'b0;
        m_count     = '0;
        m_adr       = '0;

        repeat (5) @(posedge clk);
        pon_rst <= 1'b0;
        @(negedge clk);
        check_result(m_result, decoded_output);
        check_valid(m_valid, decode_valid);
        check_address(m_adr, prog_adr);

        foreach (stim_table[i]) begin
            for (int r = 0; r < int'(stim_table[i].reps); r++) begin
                @(posedge clk);
                step_model(decode_enable, encoded_input);
                next_code = stim_table[i].code;
                if (stim_table[i].rnd) begin
                    next_code = code_width_lp'($urandom() % 32); // Half in range
                end
                decode_enable <= stim_table[i].en;
                encoded_input <= next_code;
                @(negedge clk); // Outputs settled
                check_result(m_result, decoded_output);
                check_valid(m_valid, decode_valid);
                check_address(m_adr, prog_adr);
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule : tb_decoder_host

// File: project.f
src/decoder_host_pkg.sv
src/lfsr_source.sv
src/sequence_trigger.sv
src/onehot_decode_fsm.sv
src/program_address_gen.sv
src/decoder_host_top.sv
testbench/tb_decoder_host.sv

// File: run_sim.sh
#!/bin/sh
# Build the decoder host testbench with Verilator and run it
cd "$(dirname "$0")" \
    && verilator --binary -j 0 --top-module tb_decoder_host -f project.f \
        -o tb_decoder_host \
    && ./obj_dir/tb_decoder_host \
    || exit $?
